/* Bender.yml */
package:
  name: byte_cdc

sources:
  # Design, in compile order
  - byte_cdc_pkg.sv
  - byte_packer.sv
  - cdc_fifo.sv
  - byte_unpacker.sv
  - byte_cdc_top.sv
  # Verification
  - target: test
    files:
      - byte_cdc_props.sv
      - byte_cdc_tb.sv

/* byte_cdc.f */
byte_cdc_pkg.sv
byte_packer.sv
cdc_fifo.sv
byte_unpacker.sv
byte_cdc_top.sv
byte_cdc_props.sv
byte_cdc_tb.sv

/* byte_cdc_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, word layout and FSM encodings for the
// byte stream clock domain crossing. Imported by the packer,
// the FIFO, the unpacker and the top level.
////////////////////////////////////////////////////////////

package byte_cdc_pkg;

  ////////////////////////////////////////////////////////////
  // Stream and word widths
  ////////////////////////////////////////////////////////////

  localparam int BYTE_WIDTH = 8;   // One stream byte
  localparam int WORD_WIDTH = 18;  // Two bytes plus kind and last

  // Word layout: [7:0] first byte, [15:8] second byte
  localparam int KIND_BIT = 16;  // Pair or single
  localparam int LAST_BIT = 17;  // Final byte of the word ends a frame

  ////////////////////////////////////////////////////////////
  // FIFO geometry
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH_LOG2 = 2;                     // 4 entries
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int PTR_WIDTH       = FIFO_DEPTH_LOG2 + 1;   // Extra wrap bit

  // Word kind carried in KIND_BIT
  typedef enum logic {
    KIND_PAIR   = 1'b0,  // Both bytes valid
    KIND_SINGLE = 1'b1   // Low byte only
  } kind_e;

  // Packer FSM
  typedef enum logic {
    PACK_EMPTY = 1'b0,  // Nothing held
    PACK_HALF  = 1'b1   // First byte of a pair held
  } pack_state_e;

  // Unpacker FSM
  typedef enum logic {
    UNPACK_FIRST  = 1'b0,  // Low byte goes out next
    UNPACK_SECOND = 1'b1   // High byte goes out next
  } unpack_state_e;

endpackage

/* byte_cdc_props.sv */
////////////////////////////////////////////////////////////
// Concurrent checks on the dual clock FIFO, bound into
// every cdc_fifo instance. Covers gray pointer steps, writes
// while full and head stability under back-pressure.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_cdc_props (
  input logic                                elem_in_clk_i,
  input logic                                elem_out_clk_i,
  input logic                                reset_i,
  input logic                                rst_in_i,        // Registered reset, input side
  input logic                                rst_out_i,       // Registered reset, output side
  input logic [byte_cdc_pkg::PTR_WIDTH-1:0]  rd_gray_sync_i,
  input logic [byte_cdc_pkg::PTR_WIDTH-1:0]  wr_gray_i,       // Gray write pointer as launched
  input logic [byte_cdc_pkg::PTR_WIDTH-1:0]  wr_ptr_i,        // Binary write pointer
  input logic [byte_cdc_pkg::PTR_WIDTH-1:0]  rd_ptr_sync_i,   // Read pointer seen on input side
  input logic                                write_i,
  input logic [byte_cdc_pkg::WORD_WIDTH-1:0] elem_out_i,
  input logic                                elem_out_valid_i,
  input logic                                elem_out_ready_i
);

  import byte_cdc_pkg::*;

  // Synchronized read pointer steps by one bit at most
  rd_sync_step: assert property (@(posedge elem_in_clk_i) disable iff (reset_i || rst_in_i)
    $countones(rd_gray_sync_i ^ $past(rd_gray_sync_i)) <= 1)
    else $error("synchronized read pointer changed more than one bit");

  // Write pointer entering the synchronizer, one bit per input clock
  wr_gray_step: assert property (@(posedge elem_in_clk_i) disable iff (reset_i || rst_in_i)
    $countones(wr_gray_i ^ $past(wr_gray_i)) <= 1)
    else $error("gray write pointer changed more than one bit");

  // A write needs a free entry, counted from the pointers
  no_write_full: assert property (@(posedge elem_in_clk_i) disable iff (reset_i || rst_in_i)
    write_i |-> (PTR_WIDTH'(wr_ptr_i - rd_ptr_sync_i) < FIFO_DEPTH))
    else $error("FIFO written while full");

  // Head word holds while it waits
  head_stable: assert property (@(posedge elem_out_clk_i) disable iff (reset_i || rst_out_i)
    (elem_out_valid_i && !elem_out_ready_i) |=> $stable(elem_out_i))
    else $error("FIFO head changed while stalled");

endmodule

bind cdc_fifo byte_cdc_props u_props (
  .elem_in_clk_i   (elem_in_clk_i),
  .elem_out_clk_i  (elem_out_clk_i),
  .reset_i         (reset_i),
  .rst_in_i        (rst_in_q),
  .rst_out_i       (rst_out_q),
  .rd_gray_sync_i  (rd_gray_s2),
  .wr_gray_i       (wr_gray_q),
  .wr_ptr_i        (wr_bin_q),
  .rd_ptr_sync_i   (rd_sync_bin),
  .write_i         (hsi),
  .elem_out_i      (elem_out_o),
  .elem_out_valid_i(elem_out_valid_o),
  .elem_out_ready_i(elem_out_ready_i)
);

/* byte_cdc_tb.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the byte stream crossing. Bytes go
// in on the input clock and are checked on the output clock
// against a reference queue. Five tests, one result line
// each, then a closing line with the counts.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_cdc_tb;

  import byte_cdc_pkg::*;

  localparam int TIMEOUT = 2000;  // Cycles allowed for any wait

  logic                  elem_in_clk_i;
  logic                  elem_out_clk_i;
  logic                  reset_i;
  logic [BYTE_WIDTH-1:0] byte_in_i;
  logic                  byte_in_last_i;
  logic                  byte_in_valid_i;
  logic                  byte_in_ready_o;
  logic [BYTE_WIDTH-1:0] byte_out_o;
  logic                  byte_out_last_o;
  logic                  byte_out_valid_o;
  logic                  byte_out_ready_i;

  logic [BYTE_WIDTH-1:0] exp_data_q[$];        // Bytes in flight, oldest first
  logic                  exp_last_q[$];
  int                    error_count  = 0;
  int                    test_count   = 0;
  int                    failed_tests = 0;
  logic                  hold_out     = 1'b0;  // Stall the output side
  logic                  random_ready = 1'b0;  // Random output gaps
  integer                seed         = 32'h65ff;
  integer                ready_seed;           // Own stream for output ready

  byte_cdc_top byte_cdc_top_i (.*);

  initial begin
    elem_in_clk_i = 1'b0;
    forever #5 elem_in_clk_i = ~elem_in_clk_i;    // 10 ns
  end

  initial begin
    elem_out_clk_i = 1'b0;
    forever #7 elem_out_clk_i = ~elem_out_clk_i;  // 14 ns
  end

  // Output ready, set just after the output edge
  always @(posedge elem_out_clk_i) begin
    #1;
    if (hold_out) byte_out_ready_i = 1'b0;
    else if (random_ready) byte_out_ready_i = ($random(ready_seed) % 3) != 0;
    else byte_out_ready_i = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Output monitor and compares
  ////////////////////////////////////////////////////////////

  always @(posedge elem_out_clk_i) begin
    if (!reset_i && byte_out_valid_o && byte_out_ready_i) begin
      if (exp_data_q.size() == 0) begin
        error_count++;
        $display("unexpected byte %h at %0t, nothing was sent", byte_out_o, $time);
      end else begin
        check_byte(byte_out_o, exp_data_q.pop_front());
        check_last(byte_out_last_o, exp_last_q.pop_front());
      end
    end
  end

  task automatic check_byte(input logic [BYTE_WIDTH-1:0] actual,
                            input logic [BYTE_WIDTH-1:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: byte out %h, expected %h", $time, actual, expected);
    end
  endtask

  task automatic check_last(input logic actual, input logic expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: last flag %b, expected %b", $time, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // Offer a byte for up to max_cycles, valid stays high if it was not taken
  task automatic try_send(input logic [BYTE_WIDTH-1:0] data, input logic last,
                          input int max_cycles, output logic taken);
    int waited;
    waited          = 0;
    taken           = 1'b0;
    byte_in_i       = data;
    byte_in_last_i  = last;
    byte_in_valid_i = 1'b1;
    while (!taken && waited < max_cycles) begin
      @(negedge elem_in_clk_i);
      taken = (byte_in_ready_o === 1'b1);  // Settled for the coming edge
      @(posedge elem_in_clk_i);
      waited++;
    end
    if (taken) begin
      exp_data_q.push_back(data);          // Transfer on this edge
      exp_last_q.push_back(last);
    end
    #1;
    if (taken) byte_in_valid_i = 1'b0;
  endtask

  task automatic send_byte(input logic [BYTE_WIDTH-1:0] data, input logic last);
    logic taken;
    try_send(data, last, TIMEOUT, taken);
    if (!taken) begin
      error_count++;
      $display("timeout at %0t waiting for the input to accept byte %h", $time, data);
      byte_in_valid_i = 1'b0;
    end
  endtask

  task automatic idle_in(input int cycles);
    repeat (cycles) begin
      @(posedge elem_in_clk_i);
      #1;
    end
  endtask

  // Wait until every sent byte came out, then realign to the input clock
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge elem_out_clk_i);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      error_count++;
      $display("timeout at %0t waiting for %0d bytes to come out", $time, exp_data_q.size());
    end
    repeat (4) @(posedge elem_out_clk_i);  // Room for any extra byte to show
    @(posedge elem_in_clk_i);
    #1;
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    exp_data_q.delete();                   // Anything in flight is dropped
    exp_last_q.delete();
    repeat (3) @(posedge elem_in_clk_i);
    #1;
    reset_i = 1'b0;
    repeat (3) @(posedge elem_out_clk_i);  // Output side out of reset too
    @(posedge elem_in_clk_i);
    #1;
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: FAILED with %0d errors", name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic single_byte_frames();
    int start;
    start = error_count;
    for (int i = 0; i < 8; i++) send_byte(BYTE_WIDTH'(8'h10 + i), 1'b1);
    wait_drain();
    report_test("single-byte frames", start);
  endtask

  task automatic even_odd_frames();
    int start;
    start = error_count;
    for (int i = 0; i < 4; i++) send_byte(BYTE_WIDTH'(8'h20 + i), i == 3);  // Pairs only
    for (int i = 0; i < 5; i++) send_byte(BYTE_WIDTH'(8'h40 + i), i == 4);  // Ends single
    wait_drain();
    report_test("even and odd frames", start);
  endtask

  task automatic output_backpressure();
    int   start;
    int   accepted;
    int   i;
    logic taken;
    start    = error_count;
    accepted = 0;
    hold_out = 1'b1;
    repeat (2) @(posedge elem_out_clk_i);
    @(posedge elem_in_clk_i);
    #1;
    for (i = 0; i < 16; i++) begin
      try_send(BYTE_WIDTH'(8'h60 + i), i == 15, 40, taken);
      if (!taken) break;
      accepted++;
    end
    // 4 FIFO words and 1 pending word fill up, a held byte may add one
    if (accepted < 10 || accepted > 11) begin
      error_count++;
      $display("mismatch at %0t: input took %0d bytes with the output stalled, expected 10 or 11",
               $time, accepted);
    end
    hold_out = 1'b0;
    while (i < 16) begin
      send_byte(BYTE_WIDTH'(8'h60 + i), i == 15);
      i++;
    end
    wait_drain();
    report_test("output back-pressure", start);
  endtask

  task automatic random_traffic();
    int   start;
    int   frame_left;
    logic last;
    start        = error_count;
    frame_left   = 0;
    random_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
      if (frame_left == 0) frame_left = 1 + $unsigned($random(seed)) % 7;
      frame_left--;
      last = (frame_left == 0) || (n == 199);  // Close the final frame
      idle_in($unsigned($random(seed)) % 3);
      send_byte(BYTE_WIDTH'($random(seed)), last);
    end
    wait_drain();
    random_ready = 1'b0;
    report_test("random traffic", start);
  endtask

  task automatic reset_recovery();
    int start;
    start = error_count;
    for (int i = 0; i < 8; i++) send_byte(BYTE_WIDTH'(8'ha0 + i), i == 7);
    apply_reset();                         // Part of the frame still inside
    @(negedge elem_out_clk_i);
    if (byte_out_valid_o !== 1'b0) begin
      error_count++;
      $display("mismatch at %0t: output valid %b after reset, expected 0",
               $time, byte_out_valid_o);
    end
    @(posedge elem_in_clk_i);
    #1;
    for (int i = 0; i < 6; i++) send_byte(BYTE_WIDTH'(8'hc0 + i), i == 5);
    wait_drain();
    report_test("reset recovery", start);
  endtask

  initial begin
    reset_i          = 1'b1;
    byte_in_i        = '0;
    byte_in_last_i   = 1'b0;
    byte_in_valid_i  = 1'b0;
    byte_out_ready_i = 1'b0;
    ready_seed       = $random(seed);
    apply_reset();
    single_byte_frames();
    even_odd_frames();
    output_backpressure();
    random_traffic();
    reset_recovery();
    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* byte_cdc_top.sv */
////////////////////////////////////////////////////////////
// Byte stream crossing from elem_in_clk_i to elem_out_clk_i.
// Packer, dual clock FIFO and unpacker in a chain, all
// links valid/ready. Hold reset_i for at least two edges of
// the slower clock.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_cdc_top (
  input  logic                                elem_in_clk_i,
  input  logic                                elem_out_clk_i,
  input  logic                                reset_i,
  // Input stream
  input  logic [byte_cdc_pkg::BYTE_WIDTH-1:0] byte_in_i,
  input  logic                                byte_in_last_i,
  input  logic                                byte_in_valid_i,
  output logic                                byte_in_ready_o,
  // Output stream
  output logic [byte_cdc_pkg::BYTE_WIDTH-1:0] byte_out_o,
  output logic                                byte_out_last_o,
  output logic                                byte_out_valid_o,
  input  logic                                byte_out_ready_i
);

  import byte_cdc_pkg::*;

  logic [WORD_WIDTH-1:0] word_in;         // Packer to FIFO, input clock
  logic                  word_in_valid;
  logic                  word_in_ready;
  logic [WORD_WIDTH-1:0] word_out;        // FIFO to unpacker, output clock
  logic                  word_out_valid;
  logic                  word_out_ready;

  byte_packer u_packer (
    .elem_in_clk_i  (elem_in_clk_i),
    .reset_i        (reset_i),
    .byte_in_i      (byte_in_i),
    .byte_in_last_i (byte_in_last_i),
    .byte_in_valid_i(byte_in_valid_i),
    .byte_in_ready_o(byte_in_ready_o),
    .word_o         (word_in),
    .word_valid_o   (word_in_valid),
    .word_ready_i   (word_in_ready)
  );

  cdc_fifo u_fifo (
    .elem_in_clk_i   (elem_in_clk_i),
    .reset_i         (reset_i),
    .elem_in_i       (word_in),
    .elem_in_valid_i (word_in_valid),
    .elem_in_ready_o (word_in_ready),
    .elem_out_clk_i  (elem_out_clk_i),
    .elem_out_o      (word_out),
    .elem_out_valid_o(word_out_valid),
    .elem_out_ready_i(word_out_ready)
  );

  byte_unpacker u_unpacker (
    .elem_out_clk_i  (elem_out_clk_i),
    .reset_i         (reset_i),
    .word_i          (word_out),
    .word_valid_i    (word_out_valid),
    .word_ready_o    (word_out_ready),
    .byte_out_o      (byte_out_o),
    .byte_out_last_o (byte_out_last_o),
    .byte_out_valid_o(byte_out_valid_o),
    .byte_out_ready_i(byte_out_ready_i)
  );

endmodule

/* byte_packer.sv */
////////////////////////////////////////////////////////////
// Input side of the crossing. Pairs incoming bytes into
// FIFO words and closes a word early on a frame end, which
// gives a single-byte word. One word register sits between
// the byte port and the FIFO write port.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_packer (
  input  logic                             elem_in_clk_i,
  input  logic                             reset_i,
  input  logic [byte_cdc_pkg::BYTE_WIDTH-1:0] byte_in_i,
  input  logic                             byte_in_last_i,
  input  logic                             byte_in_valid_i,
  output logic                             byte_in_ready_o,
  output logic [byte_cdc_pkg::WORD_WIDTH-1:0] word_o,
  output logic                             word_valid_o,
  input  logic                             word_ready_i
);

  import byte_cdc_pkg::*;

  pack_state_e           state_q;       // First byte held or not
  logic [BYTE_WIDTH-1:0] held_q;        // Low byte waiting for its partner
  logic [WORD_WIDTH-1:0] word_q;        // Word offered to the FIFO
  logic                  word_valid_q;
  logic                  run_q;         // Input opens one cycle after reset
  logic                  byte_hs;       // Byte accepted
  logic                  word_hs;       // Word taken by the FIFO
  logic                  complete;      // Accepted byte closes a word

  // Take a byte only if the word register is free this cycle
  assign byte_in_ready_o = run_q & (~word_valid_q | word_ready_i);
  assign byte_hs  = byte_in_valid_i & byte_in_ready_o;
  assign word_hs  = word_valid_q & word_ready_i;
  assign complete = byte_hs & ((state_q == PACK_HALF) | byte_in_last_i);

  assign word_o       = word_q;
  assign word_valid_o = word_valid_q;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge elem_in_clk_i) begin
    if (reset_i) begin
      state_q      <= PACK_EMPTY;
      word_valid_q <= 1'b0;
      run_q        <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (word_hs) word_valid_q <= 1'b0;  // Pending word gone
      if (complete) word_valid_q <= 1'b1; // New word overrides the clear
      if (byte_hs) begin
        // Held half stays only for a first byte without frame end
        state_q <= (state_q == PACK_EMPTY && !byte_in_last_i) ? PACK_HALF : PACK_EMPTY;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge elem_in_clk_i) begin
    if (byte_hs && state_q == PACK_EMPTY) held_q <= byte_in_i;
    if (complete) begin
      if (state_q == PACK_HALF) begin
        word_q[BYTE_WIDTH-1:0]            <= held_q;     // Earlier byte low
        word_q[2*BYTE_WIDTH-1:BYTE_WIDTH] <= byte_in_i;
        word_q[KIND_BIT]                  <= KIND_PAIR;
      end else begin
        word_q[BYTE_WIDTH-1:0]            <= byte_in_i;  // Lone frame-end byte
        word_q[2*BYTE_WIDTH-1:BYTE_WIDTH] <= '0;
        word_q[KIND_BIT]                  <= KIND_SINGLE;
      end
      word_q[LAST_BIT] <= byte_in_last_i;
    end
  end

endmodule

/* byte_unpacker.sv */
////////////////////////////////////////////////////////////
// Output side of the crossing. Splits the FIFO head word
// back into bytes with no added latency and restores the
// frame-end flag on the word's final byte. The word is
// popped when that final byte is taken.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_unpacker (
  input  logic                                elem_out_clk_i,
  input  logic                                reset_i,
  input  logic [byte_cdc_pkg::WORD_WIDTH-1:0] word_i,
  input  logic                                word_valid_i,
  output logic                                word_ready_o,
  output logic [byte_cdc_pkg::BYTE_WIDTH-1:0] byte_out_o,
  output logic                                byte_out_last_o,
  output logic                                byte_out_valid_o,
  input  logic                                byte_out_ready_i
);

  import byte_cdc_pkg::*;

  unpack_state_e state_q;     // Which half goes out now
  kind_e         word_kind;   // Decoded from KIND_BIT
  logic          final_byte;  // Current byte is the word's last one
  logic          byte_hs;     // Byte taken downstream

  ////////////////////////////////////////////////////////////
  // Byte select
  ////////////////////////////////////////////////////////////

  assign word_kind = kind_e'(word_i[KIND_BIT]);

  // Single words end after their low byte
  assign final_byte = (word_kind == KIND_SINGLE) || (state_q == UNPACK_SECOND);

  always_comb begin
    if (state_q == UNPACK_SECOND) begin
      byte_out_o = word_i[2*BYTE_WIDTH-1:BYTE_WIDTH];  // High byte
    end else begin
      byte_out_o = word_i[BYTE_WIDTH-1:0];             // Low byte
    end
  end

  assign byte_out_valid_o = word_valid_i;                  // Valid as soon as FIFO has data
  assign byte_out_last_o  = final_byte & word_i[LAST_BIT]; // Only on the closing byte
  assign byte_hs          = word_valid_i & byte_out_ready_i;

  // Pop the FIFO together with the last byte of the word
  assign word_ready_o = byte_hs & final_byte;

  ////////////////////////////////////////////////////////////
  // Half tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge elem_out_clk_i) begin
    if (reset_i) begin
      state_q <= UNPACK_FIRST;
    end else if (byte_hs) begin
      if (final_byte) begin
        state_q <= UNPACK_FIRST;   // Next word starts low
      end else begin
        state_q <= UNPACK_SECOND;  // Low byte of a pair went out
      end
    end
  end

endmodule

/* cdc_fifo.sv */
////////////////////////////////////////////////////////////
// Dual clock FIFO for packed words. Written on the input
// clock, read on the output clock. Pointers cross as gray
// code through two-flop synchronizers, so a change reaches
// the other side two to three edges later. Read data comes
// straight from the head entry.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdc_fifo (
  // Write side
  input  logic                                elem_in_clk_i,
  input  logic                                reset_i,
  input  logic [byte_cdc_pkg::WORD_WIDTH-1:0] elem_in_i,
  input  logic                                elem_in_valid_i,
  output logic                                elem_in_ready_o,
  // Read side
  input  logic                                elem_out_clk_i,
  output logic [byte_cdc_pkg::WORD_WIDTH-1:0] elem_out_o,
  output logic                                elem_out_valid_o,
  input  logic                                elem_out_ready_i
);

  import byte_cdc_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic                  rst_in_q;      // Reset seen on input clock
  logic                  rst_out_q;     // Reset seen on output clock

  logic [PTR_WIDTH-1:0]  wr_bin_q;      // Write pointer, binary
  logic [PTR_WIDTH-1:0]  wr_gray_q;     // Write pointer, gray, launched
  logic [PTR_WIDTH-1:0]  wr_bin_nxt;
  logic [PTR_WIDTH-1:0]  rd_bin_q;      // Read pointer, binary
  logic [PTR_WIDTH-1:0]  rd_gray_q;     // Read pointer, gray, launched
  logic [PTR_WIDTH-1:0]  rd_bin_nxt;

  logic [PTR_WIDTH-1:0]  rd_gray_s1;    // Read pointer in input domain
  logic [PTR_WIDTH-1:0]  rd_gray_s2;
  logic [PTR_WIDTH-1:0]  rd_sync_bin;
  logic [PTR_WIDTH-1:0]  wr_gray_s1;    // Write pointer in output domain
  logic [PTR_WIDTH-1:0]  wr_gray_s2;

  logic [WORD_WIDTH-1:0] mem_q [FIFO_DEPTH];

  logic                  full;
  logic                  hsi;           // Write handshake
  logic                  hso;           // Read handshake

  // Standard reflected gray to binary
  function automatic logic [PTR_WIDTH-1:0] gray2bin(input logic [PTR_WIDTH-1:0] g);
    logic [PTR_WIDTH-1:0] b;
    b[PTR_WIDTH-1] = g[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] b);
    return b ^ (b >> 1);
  endfunction

  ////////////////////////////////////////////////////////////
  // Status and handshakes
  ////////////////////////////////////////////////////////////

  assign rd_sync_bin = gray2bin(rd_gray_s2);
  assign wr_bin_nxt  = wr_bin_q + 1'b1;
  assign rd_bin_nxt  = rd_bin_q + 1'b1;

  // Full when wrap bits differ and addresses match
  assign full = (wr_bin_q[PTR_WIDTH-1] != rd_sync_bin[PTR_WIDTH-1]) &&
                (wr_bin_q[FIFO_DEPTH_LOG2-1:0] == rd_sync_bin[FIFO_DEPTH_LOG2-1:0]);

  assign elem_in_ready_o  = ~full;
  assign elem_out_valid_o = (wr_gray_s2 != rd_gray_q);  // Gray compare is enough for empty
  assign hsi = elem_in_valid_i & elem_in_ready_o;
  assign hso = elem_out_valid_o & elem_out_ready_i;

  assign elem_out_o = mem_q[rd_bin_q[FIFO_DEPTH_LOG2-1:0]];  // Head entry

  ////////////////////////////////////////////////////////////
  // Input clock domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge elem_in_clk_i) begin
    rst_in_q <= reset_i;
    if (rst_in_q) begin
      wr_bin_q   <= '0;
      wr_gray_q  <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray_q;   // First stage may go metastable
      rd_gray_s2 <= rd_gray_s1;
      if (hsi) begin
        wr_bin_q  <= wr_bin_nxt;
        wr_gray_q <= bin2gray(wr_bin_nxt);
      end
    end
  end

  always_ff @(posedge elem_in_clk_i) begin
    if (hsi) mem_q[wr_bin_q[FIFO_DEPTH_LOG2-1:0]] <= elem_in_i;
  end

  ////////////////////////////////////////////////////////////
  // Output clock domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge elem_out_clk_i) begin
    rst_out_q <= reset_i;
    if (rst_out_q) begin
      rd_bin_q   <= '0;
      rd_gray_q  <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray_q;
      wr_gray_s2 <= wr_gray_s1;
      if (hso) begin
        rd_bin_q  <= rd_bin_nxt;
        rd_gray_q <= bin2gray(rd_bin_nxt);
      end
    end
  end

endmodule
